/* all.f */
+incdir+dv
src/uart_rx_pkg.sv
src/rx_frame_fsm.sv
src/rx_shift_datapath.sv
src/rx_sync_fifo.sv
src/uart_rx_top.sv
dv/uart_rx_tb.sv

/* dv/uart_rx_tb_checks.svh */
// ----------------------------------------
// UART receiver testbench checks
// Reference model, expected entry queue
// and typed compare tasks
// ----------------------------------------

`ifndef UART_RX_TB_CHECKS_SVH
`define UART_RX_TB_CHECKS_SVH

// Entries the FIFO should hold, oldest first
rx_entry_t exp_q[$];
int        error_cnt = 0;
int        check_cnt = 0;

// Parity bit put on the line, even parity makes the count of ones even
function automatic logic line_parity(rx_cfg_t cfg, rx_byte_t data);
    logic par;
    int   i;
    par = 1'b0;
    for (i = 0; i < 5 + int'(cfg.data_width); i++) begin
        par ^= data[i];
    end
    return (cfg.parity_mode == ODD) ? ~par : par;
endfunction

// Entry the receiver should store for one frame
function automatic rx_entry_t expected_entry(rx_cfg_t cfg, rx_byte_t data,
                                             logic [1:0] stop_ok);
    rx_entry_t want;
    int        i;
    want = '0;
    // Only the configured number of low bits travel on the line
    for (i = 0; i < 5 + int'(cfg.data_width); i++) begin
        want.data[i] = data[i];
    end
    // Received bit under even parity, its inverse under odd, zero without parity
    if (cfg.parity_mode == EVEN) begin
        want.parity_bit = line_parity(cfg, data);
    end else if (cfg.parity_mode == ODD) begin
        want.parity_bit = ~line_parity(cfg, data);
    end
    want.frame_err = !stop_ok[0] || ((cfg.stop_bits == SB_2BIT) && !stop_ok[1]);
    return want;
endfunction

// Data-ready rule, given the FIFO level before the frame is written
function automatic logic ready_expected(logic stream, threshold_t thr, int level_before);
    if (!stream) begin
        return 1'b1;
    end
    if (thr == '0) begin
        return level_before >= RX_FIFO_DEPTH;
    end
    return level_before >= int'(thr);
endfunction

task automatic check_entry(input string name, input rx_entry_t got, input rx_entry_t want);
    check_cnt++;
    if (got !== want) begin
        error_cnt++;
        $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, want);
    end
endtask

task automatic check_bit(input string name, input logic got, input logic want);
    check_cnt++;
    if (got !== want) begin
        error_cnt++;
        $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, want);
    end
endtask

task automatic check_count(input string name, input int got, input int want);
    check_cnt++;
    if (got != want) begin
        error_cnt++;
        $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, want);
    end
endtask

`endif

/* dv/uart_rx_tb.sv */
// ----------------------------------------
// UART receiver testbench
// Serial frames at 16x oversampling, read
// back through the FIFO and compared
// ----------------------------------------

`timescale 1ns/100ps
`default_nettype none

module uart_rx_tb
    import uart_rx_pkg::*;
();

    // Tick every 4 clocks and 16 ticks per bit
    localparam int BIT_CLKS = 64;
    // About 70 frames of up to 12 bit times each, with close to twofold margin
    localparam int TIMEOUT_CYCLES = 100000;
    localparam rx_cfg_t CFG_8N1 = '{DW_8BIT, NO_PARITY, SB_1BIT};
    localparam rx_cfg_t CFG_8N2 = '{DW_8BIT, NO_PARITY, SB_2BIT};

    logic       clk_i;
    logic       rst_n_i;
    logic       enable_i;
    logic       ov_baud_tick_i;
    logic       rx_i;
    logic       rx_fifo_read_i;
    rx_cfg_t    cfg_i;
    logic       stream_mode_i;
    threshold_t threshold_i;
    rx_byte_t   rx_data_o;
    logic       parity_bit_o;
    logic       frame_error_o;
    logic       rx_data_ready_o;
    logic       rx_fifo_full_o;
    logic       rx_fifo_empty_o;
    logic       rx_idle_o;
    logic [1:0] tick_div = 2'd0;
    integer     seed = 63160;
    int         ready_pulses = 0;
    int         exp_ready = 0;
    int         cycle_cnt = 0;
    logic       watch_full_low = 1'b0;
    logic       watch_idle = 1'b0;

    `include "uart_rx_tb_checks.svh"

    uart_rx_top uut (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    always @(negedge clk_i) begin
        tick_div       <= tick_div + 2'd1;
        ov_baud_tick_i <= (tick_div == 2'd3);
    end

    // ----------------------------------------
    // Monitors on settled outputs
    // ----------------------------------------

    always @(posedge clk_i) begin
        if (rst_n_i) begin
            if (rx_data_ready_o) begin
                ready_pulses++;
            end
            // Read side outputs are gated off between reads
            if (!rx_fifo_read_i) begin
                check_entry("rx_data_o/parity_bit_o/frame_error_o",
                            {frame_error_o, parity_bit_o, rx_data_o}, '0);
            end
            if (watch_full_low) begin
                check_bit("rx_fifo_full_o", rx_fifo_full_o, 1'b0);
            end
            if (watch_idle) begin
                check_bit("rx_idle_o", rx_idle_o, 1'b1);
                check_bit("rx_data_ready_o", rx_data_ready_o, 1'b0);
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks: %0d, errors: %0d", check_cnt, error_cnt);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // ----------------------------------------
    // Serial driver and read side
    // ----------------------------------------

    task automatic hold_line(input logic level, input int clocks);
        rx_i = level;
        repeat (clocks) @(negedge clk_i);
    endtask

    // A low stop bit rises right after its sample so the idle FSM sees no false start edge
    task automatic drive_stop(input logic ok);
        if (ok) begin
            hold_line(1'b1, BIT_CLKS);
        end else begin
            hold_line(1'b0, BIT_CLKS / 2);
            hold_line(1'b1, BIT_CLKS / 2);
        end
    endtask

    task automatic send_frame(input rx_cfg_t cfg, input rx_byte_t data,
                              input logic [1:0] stop_ok);
        int i;
        // Starting one clock after a tick puts every sample 31 clocks into its bit
        @(posedge clk_i);
        while (!ov_baud_tick_i) begin
            @(posedge clk_i);
        end
        @(negedge clk_i);
        cfg_i = cfg;
        hold_line(1'b0, BIT_CLKS);
        for (i = 0; i < 5 + int'(cfg.data_width); i++) begin
            hold_line(data[i], BIT_CLKS);
        end
        if (cfg.parity_mode inside {EVEN, ODD}) begin
            hold_line(line_parity(cfg, data), BIT_CLKS);
        end
        drive_stop(stop_ok[0]);
        if (cfg.stop_bits == SB_2BIT) begin
            drive_stop(stop_ok[1]);
        end
        hold_line(1'b1, 16);
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (!rx_idle_o && n < BIT_CLKS) begin
            @(negedge clk_i);
            n++;
        end
        if (!rx_idle_o) begin
            error_cnt++;
            $display("Receiver did not return to idle after the stop bits at %0t", $time);
        end
    endtask

    // The queue size is the model of the FIFO level before each write
    task automatic send_and_expect(input rx_cfg_t cfg, input rx_byte_t data,
                                   input logic [1:0] stop_ok);
        if (ready_expected(stream_mode_i, threshold_i, exp_q.size())) begin
            exp_ready++;
        end
        if (exp_q.size() < RX_FIFO_DEPTH) begin
            exp_q.push_back(expected_entry(cfg, data, stop_ok));
        end
        send_frame(cfg, data, stop_ok);
        wait_idle();
    endtask

    task automatic read_and_compare();
        rx_entry_t want;
        want = exp_q.pop_front();
        @(negedge clk_i);
        rx_fifo_read_i = 1'b1;
        @(posedge clk_i);
        check_entry("rx_data_o/parity_bit_o/frame_error_o",
                    {frame_error_o, parity_bit_o, rx_data_o}, want);
        @(negedge clk_i);
        rx_fifo_read_i = 1'b0;
    endtask

    task automatic drain_fifo();
        while (exp_q.size() > 0) begin
            read_and_compare();
        end
        @(posedge clk_i);
        check_bit("rx_fifo_empty_o", rx_fifo_empty_o, 1'b1);
    endtask

    task automatic configure_mode(input logic stream, input threshold_t thr);
        @(negedge clk_i);
        stream_mode_i = stream;
        threshold_i   = thr;
        ready_pulses  = 0;
        exp_ready     = 0;
    endtask

    // ----------------------------------------
    // Scenarios
    // ----------------------------------------

    initial begin
        int         i;
        int         w;
        int         p;
        rx_cfg_t    cfg;
        logic [1:0] stops [4];
        stops          = '{2'b11, 2'b10, 2'b01, 2'b11};
        rst_n_i        = 1'b0;
        enable_i       = 1'b0;
        ov_baud_tick_i = 1'b0;
        rx_i           = RX_LINE_IDLE;
        rx_fifo_read_i = 1'b0;
        cfg_i          = CFG_8N1;
        stream_mode_i  = 1'b0;
        threshold_i    = '0;
        repeat (2) @(negedge clk_i);
        rst_n_i = 1'b1;
        @(posedge clk_i);
        check_bit("rx_idle_o", rx_idle_o, 1'b1);
        check_bit("rx_fifo_empty_o", rx_fifo_empty_o, 1'b1);
        check_bit("rx_data_ready_o", rx_data_ready_o, 1'b0);
        @(negedge clk_i);
        enable_i = 1'b1;

        // Random 8N1 frames, which also give the normal-mode pulse count
        configure_mode(1'b0, '0);
        for (i = 0; i < 16; i++) begin
            send_and_expect(CFG_8N1, rx_byte_t'($random(seed)), 2'b11);
        end
        check_count("rx_data_ready_o pulses", ready_pulses, exp_ready);
        drain_fifo();

        // Narrow widths with both parity senses
        for (w = 0; w < 3; w++) begin
            for (p = 0; p < 2; p++) begin
                cfg = '{data_width_e'(w), parity_mode_e'(p), SB_1BIT};
                send_and_expect(cfg, rx_byte_t'($random(seed)), 2'b11);
            end
        end
        drain_fifo();

        // With two stop bits a low one in either place flags the frame
        for (i = 0; i < 4; i++) begin
            send_and_expect(CFG_8N2, rx_byte_t'($random(seed)), stops[i]);
        end
        drain_fifo();

        configure_mode(1'b1, threshold_t'(4));
        repeat (8) begin
            send_and_expect(CFG_8N1, rx_byte_t'($random(seed)), 2'b11);
        end
        check_count("rx_data_ready_o pulses", ready_pulses, exp_ready);
        drain_fifo();

        // Zero threshold reports only a frame that meets a full FIFO
        configure_mode(1'b1, '0);
        watch_full_low = 1'b1;
        repeat (RX_FIFO_DEPTH + 1) begin
            send_and_expect(CFG_8N1, rx_byte_t'($random(seed)), 2'b11);
        end
        check_count("rx_data_ready_o pulses", ready_pulses, exp_ready);
        watch_full_low = 1'b0;
        drain_fifo();

        // Overflow in normal mode drops the seventeenth frame
        configure_mode(1'b0, '0);
        repeat (RX_FIFO_DEPTH + 1) begin
            send_and_expect(CFG_8N1, rx_byte_t'($random(seed)), 2'b11);
        end
        check_count("rx_data_ready_o pulses", ready_pulses, exp_ready);
        @(posedge clk_i);
        check_bit("rx_fifo_full_o", rx_fifo_full_o, 1'b1);
        check_bit("rx_fifo_empty_o", rx_fifo_empty_o, 1'b0);
        drain_fifo();

        // Disabled receiver ignores a frame on the line
        configure_mode(1'b0, '0);
        enable_i   = 1'b0;
        watch_idle = 1'b1;
        send_frame(CFG_8N1, rx_byte_t'($random(seed)), 2'b11);
        watch_idle = 1'b0;
        check_count("rx_data_ready_o pulses", ready_pulses, 0);
        check_bit("rx_fifo_empty_o", rx_fifo_empty_o, 1'b1);

        $display("Checks: %0d, errors: %0d", check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule : uart_rx_tb

`default_nettype wire

/* src/rx_frame_fsm.sv */
// ----------------------------------------
// UART receive frame FSM
// Counts oversample ticks and bits, and
// strobes the datapath at each bit middle
// ----------------------------------------

`timescale 1ns/100ps
`default_nettype none

module rx_frame_fsm
    import uart_rx_pkg::*;
(
    input  wire logic      clk_i,
    input  wire logic      rst_n_i,
    input  wire logic      enable_i,
    input  wire logic      ov_baud_tick_i,
    input  wire logic      rx_i,
    input  wire rx_cfg_t   cfg_i,
    output rx_sample_ctl_t sample_ctl_o,
    output logic           frame_done_o,
    output logic           idle_o
);

    // Tick count at which the middle of a bit is reached
    localparam tick_cnt_t HALF_LAST = tick_cnt_t'(HALF_BIT_TICKS - 4'd1);
    localparam tick_cnt_t BIT_LAST  = tick_cnt_t'(OVERSAMPLE_TICKS - 5'd1);

    rx_state_e state_q, state_d;
    tick_cnt_t tick_q, tick_d;
    bit_cnt_t  bit_q, bit_d;
    logic      stop_q, stop_d;
    logic      done_q, done_d;
    bit_cnt_t  last_bit;
    logic      no_parity;

    // Index of the final data bit: 4 for five bits up to 7 for eight
    assign last_bit  = bit_cnt_t'(3'd4) + bit_cnt_t'(cfg_i.data_width);
    assign no_parity = cfg_i.parity_mode inside {NO_PARITY, NO_PARITY_ALT};

    // ----------------------------------------
    // Next state and sampling strobes
    // ----------------------------------------

    always_comb begin
        state_d      = state_q;
        tick_d       = tick_q;
        bit_d        = bit_q;
        stop_d       = stop_q;
        done_d       = 1'b0;
        sample_ctl_o = '0;

        case (state_q)
            RX_IDLE: begin
                // A low line while enabled is taken as the start edge
                if ((rx_i != RX_LINE_IDLE) && enable_i) begin
                    sample_ctl_o.clear = 1'b1;
                    tick_d             = '0;
                    state_d            = RX_START;
                end
            end

            RX_START: begin
                if (ov_baud_tick_i) begin
                    if (tick_q == HALF_LAST) begin
                        // Middle of the start bit, data bits follow
                        tick_d  = '0;
                        bit_d   = '0;
                        state_d = RX_SAMPLE;
                    end else begin
                        tick_d = tick_q + 1'b1;
                    end
                end
            end

            RX_SAMPLE: begin
                if (ov_baud_tick_i) begin
                    // The 4-bit counter wraps to zero on the sample tick
                    tick_d = tick_q + 1'b1;
                    if (tick_q == BIT_LAST) begin
                        sample_ctl_o.shift = 1'b1;
                        bit_d              = bit_q + 1'b1;
                        if (bit_q == last_bit) begin
                            stop_d  = 1'b0;
                            state_d = no_parity ? RX_STOP : RX_PARITY;
                        end
                    end
                end
            end

            RX_PARITY: begin
                if (ov_baud_tick_i) begin
                    tick_d = tick_q + 1'b1;
                    if (tick_q == BIT_LAST) begin
                        sample_ctl_o.take_parity = 1'b1;
                        stop_d                   = 1'b0;
                        state_d                  = RX_STOP;
                    end
                end
            end

            RX_STOP: begin
                if (ov_baud_tick_i) begin
                    tick_d = tick_q + 1'b1;
                    if (tick_q == BIT_LAST) begin
                        sample_ctl_o.take_stop = 1'b1;
                        if ((cfg_i.stop_bits == SB_2BIT) && !stop_q) begin
                            stop_d = 1'b1;
                        end else begin
                            // Final stop sample, the frame completes next cycle
                            done_d  = 1'b1;
                            state_d = RX_IDLE;
                        end
                    end
                end
            end

            default: begin
                state_d = RX_IDLE;
            end
        endcase
    end

    // ----------------------------------------
    // State registers
    // ----------------------------------------

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= RX_IDLE;
            tick_q  <= '0;
            bit_q   <= '0;
            stop_q  <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            tick_q  <= tick_d;
            bit_q   <= bit_d;
            stop_q  <= stop_d;
            done_q  <= done_d;
        end
    end

    assign frame_done_o = done_q;
    assign idle_o       = (state_q == RX_IDLE);

    // The datapath acts on a single strobe per cycle
    a_one_strobe : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(sample_ctl_o));

endmodule : rx_frame_fsm

`default_nettype wire

/* src/rx_shift_datapath.sv */
// ----------------------------------------
// UART receive datapath
// Shifts in data bits, captures parity and
// stop bits and builds the FIFO entry
// ----------------------------------------

`timescale 1ns/100ps
`default_nettype none

module rx_shift_datapath
    import uart_rx_pkg::*;
(
    input  wire logic           clk_i,
    input  wire logic           rst_n_i,
    input  wire logic           rx_i,
    input  wire rx_cfg_t        cfg_i,
    input  wire rx_sample_ctl_t sample_ctl_i,
    output rx_entry_t           entry_o
);

    rx_byte_t shift_q;
    logic     parity_q;
    logic     stop_ok_q;

    // ----------------------------------------
    // Capture registers
    // ----------------------------------------

    // LSB arrives first, so each bit enters at the top and moves down
    always_ff @(posedge clk_i) begin
        if (sample_ctl_i.clear) begin
            shift_q  <= '0;
            parity_q <= 1'b0;
        end else begin
            if (sample_ctl_i.shift) begin
                shift_q <= {rx_i, shift_q[7:1]};
            end
            if (sample_ctl_i.take_parity) begin
                parity_q <= rx_i;
            end
        end
    end

    // A single low stop sample marks the whole frame as bad
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            stop_ok_q <= 1'b1;
        end else if (sample_ctl_i.clear) begin
            stop_ok_q <= 1'b1;
        end else if (sample_ctl_i.take_stop) begin
            stop_ok_q <= stop_ok_q & rx_i;
        end
    end

    // ----------------------------------------
    // Entry formatting
    // ----------------------------------------

    always_comb begin
        // Narrow frames leave their bits at the top of the register
        case (cfg_i.data_width)
            DW_5BIT: entry_o.data = {3'b000, shift_q[7:3]};
            DW_6BIT: entry_o.data = {2'b00, shift_q[7:2]};
            DW_7BIT: entry_o.data = {1'b0, shift_q[7:1]};
            default: entry_o.data = shift_q;
        endcase

        // Odd parity is reported inverted, no parity reports zero
        case (cfg_i.parity_mode)
            EVEN:    entry_o.parity_bit = parity_q;
            ODD:     entry_o.parity_bit = ~parity_q;
            default: entry_o.parity_bit = 1'b0;
        endcase

        entry_o.frame_err = ~stop_ok_q;
    end

endmodule : rx_shift_datapath

`default_nettype wire

/* src/rx_sync_fifo.sv */
// ----------------------------------------
// Receive FIFO, first word fall through
// Head entry is visible without a read and
// writes to a full FIFO are dropped
// ----------------------------------------

`timescale 1ns/100ps
`default_nettype none

module rx_sync_fifo
    import uart_rx_pkg::*;
(
    input  wire logic      clk_i,
    input  wire logic      rst_n_i,
    input  wire logic      write_i,
    input  wire rx_entry_t wr_entry_i,
    input  wire logic      read_i,
    output rx_entry_t      rd_entry_o,
    output fifo_level_t    level_o,
    output logic           full_o,
    output logic           empty_o
);

    rx_entry_t mem_q [RX_FIFO_DEPTH];

    logic [RX_FIFO_PTR_W - 1:0] wr_ptr_q;
    logic [RX_FIFO_PTR_W - 1:0] rd_ptr_q;
    fifo_level_t                level_q;
    logic                       do_write;
    logic                       do_read;

    // Qualified operations, the FIFO protects itself from both ends
    assign do_write = write_i & ~full_o;
    assign do_read  = read_i & ~empty_o;

    // ----------------------------------------
    // Storage
    // ----------------------------------------

    always_ff @(posedge clk_i) begin
        if (do_write) begin
            mem_q[wr_ptr_q] <= wr_entry_i;
        end
    end

    // ----------------------------------------
    // Pointers and level
    // ----------------------------------------

    // Depth is a power of two so the pointers wrap on their own
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            level_q  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_read) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   level_q <= level_q + 1'b1;
                2'b01:   level_q <= level_q - 1'b1;
                default: level_q <= level_q;
            endcase
        end
    end

    assign rd_entry_o = mem_q[rd_ptr_q];
    assign level_o    = level_q;
    assign full_o     = (level_q == fifo_level_t'(RX_FIFO_DEPTH));
    assign empty_o    = (level_q == '0);

    // Level stays within the storage even under back to back traffic
    a_level_bound : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        level_q <= fifo_level_t'(RX_FIFO_DEPTH));

endmodule : rx_sync_fifo

`default_nettype wire

/* src/uart_rx_pkg.sv */
// ----------------------------------------
// UART receiver shared definitions
// Timing constants, field widths, config
// encodings and the FIFO entry layout
// ----------------------------------------

`default_nettype none

package uart_rx_pkg;

    // Oversampling: 16 ticks per bit, start bit checked at its middle
    localparam logic [4:0] OVERSAMPLE_TICKS = 5'd16;
    localparam logic [3:0] HALF_BIT_TICKS   = 4'd8;

    // Receive FIFO sizing
    localparam int unsigned RX_FIFO_DEPTH = 16;
    localparam int unsigned RX_FIFO_PTR_W = $clog2(RX_FIFO_DEPTH);

    // Level of the serial line between frames
    localparam logic RX_LINE_IDLE = 1'b1;

    typedef logic [3:0] tick_cnt_t;
    typedef logic [2:0] bit_cnt_t;
    typedef logic [7:0] rx_byte_t;
    typedef logic [$clog2(RX_FIFO_DEPTH + 1) - 1:0] fifo_level_t;
    typedef logic [4:0] threshold_t;

    typedef enum logic [1:0] {DW_5BIT, DW_6BIT, DW_7BIT, DW_8BIT} data_width_e;

    // Both codes with the upper bit set disable parity
    typedef enum logic [1:0] {EVEN, ODD, NO_PARITY, NO_PARITY_ALT} parity_mode_e;

    // Any code other than SB_2BIT means a single stop bit
    typedef enum logic [1:0] {SB_1BIT, SB_2BIT} stop_bits_e;

    typedef enum logic [2:0] {RX_IDLE, RX_START, RX_SAMPLE, RX_PARITY, RX_STOP} rx_state_e;

    typedef struct packed {
        data_width_e  data_width;
        parity_mode_e parity_mode;
        stop_bits_e   stop_bits;
    } rx_cfg_t;

    // One-cycle strobes from the frame FSM to the datapath
    typedef struct packed {
        logic clear;
        logic shift;
        logic take_parity;
        logic take_stop;
    } rx_sample_ctl_t;

    typedef struct packed {
        logic     frame_err;
        logic     parity_bit;
        rx_byte_t data;
    } rx_entry_t;

endpackage : uart_rx_pkg

`default_nettype wire

/* src/uart_rx_top.sv */
// ----------------------------------------
// UART receiver top level
// Frame FSM, datapath and FIFO, with the
// data-ready rule and read-side gating
// ----------------------------------------

`timescale 1ns/100ps
`default_nettype none

module uart_rx_top
    import uart_rx_pkg::*;
(
    input  wire logic       clk_i,
    input  wire logic       rst_n_i,
    input  wire logic       enable_i,
    input  wire logic       ov_baud_tick_i,
    input  wire logic       rx_i,
    input  wire logic       rx_fifo_read_i,
    input  wire rx_cfg_t    cfg_i,
    input  wire logic       stream_mode_i,
    input  wire threshold_t threshold_i,
    output rx_byte_t        rx_data_o,
    output logic            parity_bit_o,
    output logic            frame_error_o,
    output logic            rx_data_ready_o,
    output logic            rx_fifo_full_o,
    output logic            rx_fifo_empty_o,
    output logic            rx_idle_o
);

    rx_sample_ctl_t sample_ctl;
    logic           frame_done;
    rx_entry_t      wr_entry;
    rx_entry_t      head_entry;
    fifo_level_t    fifo_level;
    logic           fifo_full;
    logic           full_only;
    logic           rd_valid;

    rx_frame_fsm u_fsm (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .enable_i       (enable_i),
        .ov_baud_tick_i (ov_baud_tick_i),
        .rx_i           (rx_i),
        .cfg_i          (cfg_i),
        .sample_ctl_o   (sample_ctl),
        .frame_done_o   (frame_done),
        .idle_o         (rx_idle_o)
    );

    rx_shift_datapath u_datapath (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .rx_i         (rx_i),
        .cfg_i        (cfg_i),
        .sample_ctl_i (sample_ctl),
        .entry_o      (wr_entry)
    );

    // Each finished frame is offered to the FIFO, which drops it when full
    rx_sync_fifo u_fifo (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .write_i    (frame_done),
        .wr_entry_i (wr_entry),
        .read_i     (rx_fifo_read_i),
        .rd_entry_o (head_entry),
        .level_o    (fifo_level),
        .full_o     (fifo_full),
        .empty_o    (rx_fifo_empty_o)
    );

    // ----------------------------------------
    // Data-ready and full flag
    // ----------------------------------------

    // Stream mode with a zero threshold only reports a full FIFO
    assign full_only = stream_mode_i && (threshold_i == '0);

    always_comb begin
        rx_data_ready_o = 1'b0;
        if (frame_done) begin
            if (!stream_mode_i) begin
                rx_data_ready_o = 1'b1;
            end else if (full_only) begin
                rx_data_ready_o = fifo_full;
            end else begin
                // Level seen before this frame is written
                rx_data_ready_o = (fifo_level >= fifo_level_t'(threshold_i));
            end
        end
    end

    // The data-ready pulse already signals fullness in that mode
    assign rx_fifo_full_o = full_only ? 1'b0 : fifo_full;

    // Head entry is shown only during a read that actually pops
    assign rd_valid      = rx_fifo_read_i & ~rx_fifo_empty_o;
    assign rx_data_o     = rd_valid ? head_entry.data : '0;
    assign parity_bit_o  = rd_valid & head_entry.parity_bit;
    assign frame_error_o = rd_valid & head_entry.frame_err;

    // Data ready comes with the frame end, right after the FSM left the stop bits
    a_ready_at_frame_end : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rx_data_ready_o |-> frame_done && rx_idle_o && $past(!rx_idle_o));

endmodule : uart_rx_top

`default_nettype wire
